/* verilog/aib_sm_pkg.sv */
/*
 * Shared definitions for the AIB master reset and calibration sequencer.
 * Holds the synchronizer depth and the state encodings of the three
 * master state machines. Modules pull these in by a wildcard import.
 */

package aib_sm_pkg;

    // ======================================================================
    // Synchronizer depth
    // ======================================================================
    localparam int SYNC_STAGES = 2; // Flops per bit and reset synchronizer

    // ======================================================================
    // State encodings
    // ======================================================================
    typedef enum logic [1:0] {
        OSC_WAIT_RDY   = 2'd0, // Idle until config done
        OSC_XFER_EN    = 2'd1,
        OSC_XFER_ALIVE = 2'd2  // Terminal until reset
    } osc_state_e;

    // Remote TX to local RX calibration
    typedef enum logic [2:0] {
        RX_WAIT_REQ             = 3'd0,
        RX_WAIT_REMOTE_DCC_DONE = 3'd1,
        RX_SEND_DLL_LOCK_REQ    = 3'd2,
        RX_DLL_LOCKED           = 3'd3,
        RX_XFER_EN              = 3'd4
    } rx_cal_state_e;

    // Local TX to remote RX calibration
    typedef enum logic [2:0] {
        TX_WAIT_REQ             = 3'd0,
        TX_SEND_DCC_CAL_REQ     = 3'd1,
        TX_WAIT_REMOTE_DLL_LOCK = 3'd2,
        TX_WAIT_REMOTE_XFER_EN  = 3'd3,
        TX_XFER_EN              = 3'd4
    } tx_cal_state_e;

endpackage

/* verilog/aib_reset_sync.sv */
/*
 * Reset synchronizer for the master side on osc_clk.
 * Combines the adapter reset with config done into ms_reset_n_sync and
 * also synchronizes config done alone. Both assert immediately and
 * release SYNC_STAGES edges after their source goes high.
 */

`timescale 1ns/1ns

module aib_reset_sync
    import aib_sm_pkg::*;
(
    input  logic osc_clk,
    input  logic i_reset_n,
    input  logic i_config_done,
    output logic o_reset_n_sync,
    output logic o_config_done_sync
);

    logic                   reset_src;
    logic [SYNC_STAGES-1:0] reset_q;
    logic [SYNC_STAGES-1:0] cfg_done_q;

    assign reset_src = i_reset_n & i_config_done; // Either low holds reset

    always_ff @(posedge osc_clk or negedge reset_src) begin
        if (!reset_src) begin
            reset_q <= '0;
        end else begin
            reset_q <= {reset_q[SYNC_STAGES-2:0], 1'b1};
        end
    end

    always_ff @(posedge osc_clk or negedge i_config_done) begin
        if (!i_config_done) begin
            cfg_done_q <= '0;
        end else begin
            cfg_done_q <= {cfg_done_q[SYNC_STAGES-2:0], 1'b1};
        end
    end

    assign o_reset_n_sync     = reset_q[SYNC_STAGES-1];
    assign o_config_done_sync = cfg_done_q[SYNC_STAGES-1];

endmodule

/* verilog/aib_status_sync.sv */
/*
 * Bit synchronizers for the status levels the master samples.
 * Each input passes through SYNC_STAGES flops on osc_clk. The remote
 * oscillator enable is held clear by config done, the rest by reset.
 */

`timescale 1ns/1ns

module aib_status_sync
    import aib_sm_pkg::*;
(
    input  logic osc_clk,
    input  logic ms_reset_n_sync,
    input  logic i_config_done_sync,
    input  logic i_sl_osc_transfer_en,
    input  logic i_sl_tx_dcc_dll_lock_req,
    input  logic i_ms_rx_dcc_dll_lock_req,
    input  logic i_ms_rx_dll_lock,
    input  logic i_sl_tx_dcc_cal_done,
    input  logic i_sl_rx_dcc_dll_lock_req,
    input  logic i_ms_tx_dcc_dll_lock_req,
    input  logic i_ms_tx_dcc_cal_done,
    input  logic i_sl_rx_dll_lock,
    input  logic i_sl_rx_transfer_en,
    output logic o_sl_osc_transfer_en,
    output logic o_sl_tx_dcc_dll_lock_req,
    output logic o_ms_rx_dcc_dll_lock_req,
    output logic o_ms_rx_dll_lock,
    output logic o_sl_tx_dcc_cal_done,
    output logic o_sl_rx_dcc_dll_lock_req,
    output logic o_ms_tx_dcc_dll_lock_req,
    output logic o_ms_tx_dcc_cal_done,
    output logic o_sl_rx_dll_lock,
    output logic o_sl_rx_transfer_en
);

    logic [SYNC_STAGES-1:0]      osc_en_q;
    logic [8:0]                  stat_in;
    logic [SYNC_STAGES-1:0][8:0] stat_q;  // One 9-bit word per stage

    // ======================================================================
    // Remote oscillator enable, cleared by config done only
    // ======================================================================
    always_ff @(posedge osc_clk or negedge i_config_done_sync) begin
        if (!i_config_done_sync) begin
            osc_en_q <= '0;
        end else begin
            osc_en_q <= {osc_en_q[SYNC_STAGES-2:0], i_sl_osc_transfer_en};
        end
    end

    assign o_sl_osc_transfer_en = osc_en_q[SYNC_STAGES-1];

    // ======================================================================
    // Calibration status levels
    // ======================================================================
    assign stat_in = {i_sl_tx_dcc_dll_lock_req, i_ms_rx_dcc_dll_lock_req, i_ms_rx_dll_lock,
                      i_sl_tx_dcc_cal_done, i_sl_rx_dcc_dll_lock_req, i_ms_tx_dcc_dll_lock_req,
                      i_ms_tx_dcc_cal_done, i_sl_rx_dll_lock, i_sl_rx_transfer_en};

    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            stat_q <= '0;
        end else begin
            stat_q <= {stat_q[SYNC_STAGES-2:0], stat_in}; // Stage 0 takes the raw level
        end
    end

    assign {o_sl_tx_dcc_dll_lock_req, o_ms_rx_dcc_dll_lock_req, o_ms_rx_dll_lock,
            o_sl_tx_dcc_cal_done, o_sl_rx_dcc_dll_lock_req, o_ms_tx_dcc_dll_lock_req,
            o_ms_tx_dcc_cal_done, o_sl_rx_dll_lock, o_sl_rx_transfer_en} = stat_q[SYNC_STAGES-1];

endmodule

/* verilog/aib_osc_sm.sv */
/*
 * Master oscillator transfer handshake.
 * Enables the oscillator transfer once config done is released, then
 * waits for the remote enable and marks the link alive until reset.
 */

`timescale 1ns/1ns

module aib_osc_sm
    import aib_sm_pkg::*;
(
    input  logic osc_clk,
    input  logic i_config_done_sync,
    input  logic i_sl_osc_transfer_en,
    output logic o_osc_transfer_en,
    output logic o_osc_transfer_alive
);

    osc_state_e state_q;
    osc_state_e state_d;
    logic       xfer_en_d;
    logic       alive_d;

    always_comb begin
        case (state_q)
            OSC_WAIT_RDY:   state_d = OSC_XFER_EN; // Master needs no remote go-ahead
            OSC_XFER_EN:    state_d = i_sl_osc_transfer_en ? OSC_XFER_ALIVE : OSC_XFER_EN;
            OSC_XFER_ALIVE: state_d = OSC_XFER_ALIVE;
            default:        state_d = OSC_WAIT_RDY;
        endcase
    end

    // Sticky flags, cleared only back in idle
    assign xfer_en_d = (state_q == OSC_WAIT_RDY) ? 1'b0 :
                       (state_q == OSC_XFER_EN) | o_osc_transfer_en;
    assign alive_d   = (state_q == OSC_WAIT_RDY) ? 1'b0 :
                       (state_q == OSC_XFER_ALIVE) | o_osc_transfer_alive;

    always_ff @(posedge osc_clk or negedge i_config_done_sync) begin
        if (!i_config_done_sync) begin
            state_q              <= OSC_WAIT_RDY;
            o_osc_transfer_en    <= 1'b0;
            o_osc_transfer_alive <= 1'b0;
        end else begin
            state_q              <= state_d;
            o_osc_transfer_en    <= xfer_en_d;
            o_osc_transfer_alive <= alive_d;
        end
    end

endmodule

/* verilog/aib_rx_cal_sm.sv */
/*
 * Remote TX to local RX calibration sequencer.
 * Starts once the oscillator link is alive and a lock request is seen,
 * waits for remote DCC done and local DLL lock, then enables transfer.
 * Dropping either request returns the machine to idle.
 */

`timescale 1ns/1ns

module aib_rx_cal_sm
    import aib_sm_pkg::*;
(
    input  logic osc_clk,
    input  logic ms_reset_n_sync,
    input  logic i_osc_transfer_alive,
    input  logic i_sl_tx_dcc_dll_lock_req,
    input  logic i_ms_rx_dcc_dll_lock_req,
    input  logic i_sl_tx_dcc_cal_done,
    input  logic i_ms_rx_dll_lock,
    output logic o_rx_async_rst,
    output logic o_rx_dll_lock_req,
    output logic o_rx_dll_lock,
    output logic o_rx_transfer_en
);

    rx_cal_state_e state_q;
    rx_cal_state_e state_d;
    logic          both_req;
    logic          idle;

    assign both_req = i_sl_tx_dcc_dll_lock_req & i_ms_rx_dcc_dll_lock_req;
    assign idle     = (state_q == RX_WAIT_REQ);

    always_comb begin
        state_d = state_q;
        case (state_q)
            RX_WAIT_REQ: begin
                if (i_osc_transfer_alive & (i_sl_tx_dcc_dll_lock_req | i_ms_rx_dcc_dll_lock_req))
                    state_d = RX_WAIT_REMOTE_DCC_DONE;
            end
            RX_WAIT_REMOTE_DCC_DONE: begin
                if (i_sl_tx_dcc_cal_done) state_d = RX_SEND_DLL_LOCK_REQ;
            end
            RX_SEND_DLL_LOCK_REQ: begin
                if (i_ms_rx_dll_lock) state_d = RX_DLL_LOCKED;
            end
            RX_DLL_LOCKED: state_d = RX_XFER_EN;
            RX_XFER_EN:    state_d = RX_XFER_EN;
            default:       state_d = RX_WAIT_REQ;
        endcase
        if (!idle && !both_req) state_d = RX_WAIT_REQ; // Abort on any request drop
    end

    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            state_q           <= RX_WAIT_REQ;
            o_rx_async_rst    <= 1'b0;
            o_rx_dll_lock_req <= 1'b0;
            o_rx_dll_lock     <= 1'b0;
            o_rx_transfer_en  <= 1'b0;
        end else begin
            state_q           <= state_d;
            o_rx_async_rst    <= !idle;  // Release while sequencing
            o_rx_dll_lock_req <= !idle & ((state_q == RX_SEND_DLL_LOCK_REQ) | o_rx_dll_lock_req);
            o_rx_dll_lock     <= !idle & ((state_q == RX_DLL_LOCKED) | o_rx_dll_lock);
            o_rx_transfer_en  <= !idle & ((state_q == RX_XFER_EN) | o_rx_transfer_en);
        end
    end

endmodule

/* verilog/aib_tx_cal_sm.sv */
/*
 * Local TX to remote RX calibration sequencer.
 * Needs the link alive and both lock requests before it asks for DCC
 * calibration, then waits on remote DLL lock and remote RX transfer
 * enable. Dropping either request returns the machine to idle.
 */

`timescale 1ns/1ns

module aib_tx_cal_sm
    import aib_sm_pkg::*;
(
    input  logic osc_clk,
    input  logic ms_reset_n_sync,
    input  logic i_osc_transfer_alive,
    input  logic i_sl_rx_dcc_dll_lock_req,
    input  logic i_ms_tx_dcc_dll_lock_req,
    input  logic i_ms_tx_dcc_cal_done,
    input  logic i_sl_rx_dll_lock,
    input  logic i_sl_rx_transfer_en,
    output logic o_tx_async_rst,
    output logic o_tx_dcc_cal_req,
    output logic o_tx_dcc_cal_done,
    output logic o_tx_transfer_en
);

    tx_cal_state_e state_q;
    tx_cal_state_e state_d;
    logic          both_req;
    logic          idle;

    assign both_req = i_sl_rx_dcc_dll_lock_req & i_ms_tx_dcc_dll_lock_req;
    assign idle     = (state_q == TX_WAIT_REQ);

    always_comb begin
        state_d = state_q;
        case (state_q)
            TX_WAIT_REQ: begin
                if (i_osc_transfer_alive & both_req) state_d = TX_SEND_DCC_CAL_REQ;
            end
            TX_SEND_DCC_CAL_REQ: begin
                if (i_ms_tx_dcc_cal_done) state_d = TX_WAIT_REMOTE_DLL_LOCK;
            end
            TX_WAIT_REMOTE_DLL_LOCK: begin
                if (i_sl_rx_dll_lock) state_d = TX_WAIT_REMOTE_XFER_EN;
            end
            TX_WAIT_REMOTE_XFER_EN: begin
                if (i_sl_rx_transfer_en) state_d = TX_XFER_EN;
            end
            TX_XFER_EN: state_d = TX_XFER_EN;
            default:    state_d = TX_WAIT_REQ;
        endcase
        if (!idle && !both_req) state_d = TX_WAIT_REQ; // Abort on any request drop
    end

    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            state_q           <= TX_WAIT_REQ;
            o_tx_async_rst    <= 1'b0;
            o_tx_dcc_cal_req  <= 1'b0;
            o_tx_dcc_cal_done <= 1'b0;
            o_tx_transfer_en  <= 1'b0;
        end else begin
            state_q           <= state_d;
            o_tx_async_rst    <= !idle;
            o_tx_dcc_cal_req  <= !idle & ((state_q == TX_SEND_DCC_CAL_REQ) | o_tx_dcc_cal_req);
            o_tx_dcc_cal_done <= !idle & ((state_q == TX_WAIT_REMOTE_DLL_LOCK) | o_tx_dcc_cal_done);
            o_tx_transfer_en  <= !idle & ((state_q == TX_XFER_EN) | o_tx_transfer_en);
        end
    end

endmodule

/* verilog/aib_sm_top.sv */
/*
 * Master side AIB reset and calibration sequencer, all on osc_clk.
 * Reset sync feeds the status synchronizers and the oscillator
 * handshake, whose alive flag starts the RX and TX calibration machines.
 */

`timescale 1ns/1ns

module aib_sm_top (
    input  logic osc_clk,
    input  logic i_reset_n,
    input  logic i_config_done,
    input  logic i_sl_osc_transfer_en,
    input  logic i_sl_tx_dcc_dll_lock_req,
    input  logic i_ms_rx_dcc_dll_lock_req,
    input  logic i_ms_rx_dll_lock,
    input  logic i_sl_tx_dcc_cal_done,
    input  logic i_sl_rx_dcc_dll_lock_req,
    input  logic i_ms_tx_dcc_dll_lock_req,
    input  logic i_ms_tx_dcc_cal_done,
    input  logic i_sl_rx_dll_lock,
    input  logic i_sl_rx_transfer_en,
    output logic o_ms_osc_transfer_en,
    output logic o_ms_osc_transfer_alive,
    output logic o_ms_rx_async_rst,
    output logic o_ms_rx_dll_lock_req,
    output logic o_ms_rx_dll_lock,
    output logic o_ms_rx_transfer_en,
    output logic o_ms_tx_async_rst,
    output logic o_ms_tx_dcc_cal_req,
    output logic o_ms_tx_dcc_cal_done,
    output logic o_ms_tx_transfer_en
);

    logic ms_reset_n_sync;
    logic config_done_sync;
    logic sl_osc_transfer_en_sync;
    logic sl_tx_dcc_dll_lock_req_sync;
    logic ms_rx_dcc_dll_lock_req_sync;
    logic ms_rx_dll_lock_sync;
    logic sl_tx_dcc_cal_done_sync;
    logic sl_rx_dcc_dll_lock_req_sync;
    logic ms_tx_dcc_dll_lock_req_sync;
    logic ms_tx_dcc_cal_done_sync;
    logic sl_rx_dll_lock_sync;
    logic sl_rx_transfer_en_sync;

    // ======================================================================
    // Reset and status synchronization
    // ======================================================================
    aib_reset_sync aib_reset_sync_inst (
        .osc_clk            (osc_clk),
        .i_reset_n          (i_reset_n),
        .i_config_done      (i_config_done),
        .o_reset_n_sync     (ms_reset_n_sync),
        .o_config_done_sync (config_done_sync)
    );

    aib_status_sync aib_status_sync_inst (
        .osc_clk                  (osc_clk),
        .ms_reset_n_sync          (ms_reset_n_sync),
        .i_config_done_sync       (config_done_sync),
        .i_sl_osc_transfer_en     (i_sl_osc_transfer_en),
        .i_sl_tx_dcc_dll_lock_req (i_sl_tx_dcc_dll_lock_req),
        .i_ms_rx_dcc_dll_lock_req (i_ms_rx_dcc_dll_lock_req),
        .i_ms_rx_dll_lock         (i_ms_rx_dll_lock),
        .i_sl_tx_dcc_cal_done     (i_sl_tx_dcc_cal_done),
        .i_sl_rx_dcc_dll_lock_req (i_sl_rx_dcc_dll_lock_req),
        .i_ms_tx_dcc_dll_lock_req (i_ms_tx_dcc_dll_lock_req),
        .i_ms_tx_dcc_cal_done     (i_ms_tx_dcc_cal_done),
        .i_sl_rx_dll_lock         (i_sl_rx_dll_lock),
        .i_sl_rx_transfer_en      (i_sl_rx_transfer_en),
        .o_sl_osc_transfer_en     (sl_osc_transfer_en_sync),
        .o_sl_tx_dcc_dll_lock_req (sl_tx_dcc_dll_lock_req_sync),
        .o_ms_rx_dcc_dll_lock_req (ms_rx_dcc_dll_lock_req_sync),
        .o_ms_rx_dll_lock         (ms_rx_dll_lock_sync),
        .o_sl_tx_dcc_cal_done     (sl_tx_dcc_cal_done_sync),
        .o_sl_rx_dcc_dll_lock_req (sl_rx_dcc_dll_lock_req_sync),
        .o_ms_tx_dcc_dll_lock_req (ms_tx_dcc_dll_lock_req_sync),
        .o_ms_tx_dcc_cal_done     (ms_tx_dcc_cal_done_sync),
        .o_sl_rx_dll_lock         (sl_rx_dll_lock_sync),
        .o_sl_rx_transfer_en      (sl_rx_transfer_en_sync)
    );

    // ======================================================================
    // State machines
    // ======================================================================
    aib_osc_sm aib_osc_sm_inst (
        .osc_clk              (osc_clk),
        .i_config_done_sync   (config_done_sync),
        .i_sl_osc_transfer_en (sl_osc_transfer_en_sync),
        .o_osc_transfer_en    (o_ms_osc_transfer_en),
        .o_osc_transfer_alive (o_ms_osc_transfer_alive)
    );

    aib_rx_cal_sm aib_rx_cal_sm_inst (
        .osc_clk                  (osc_clk),
        .ms_reset_n_sync          (ms_reset_n_sync),
        .i_osc_transfer_alive     (o_ms_osc_transfer_alive),
        .i_sl_tx_dcc_dll_lock_req (sl_tx_dcc_dll_lock_req_sync),
        .i_ms_rx_dcc_dll_lock_req (ms_rx_dcc_dll_lock_req_sync),
        .i_sl_tx_dcc_cal_done     (sl_tx_dcc_cal_done_sync),
        .i_ms_rx_dll_lock         (ms_rx_dll_lock_sync),
        .o_rx_async_rst           (o_ms_rx_async_rst),
        .o_rx_dll_lock_req        (o_ms_rx_dll_lock_req),
        .o_rx_dll_lock            (o_ms_rx_dll_lock),
        .o_rx_transfer_en         (o_ms_rx_transfer_en)
    );

    aib_tx_cal_sm aib_tx_cal_sm_inst (
        .osc_clk                  (osc_clk),
        .ms_reset_n_sync          (ms_reset_n_sync),
        .i_osc_transfer_alive     (o_ms_osc_transfer_alive),
        .i_sl_rx_dcc_dll_lock_req (sl_rx_dcc_dll_lock_req_sync),
        .i_ms_tx_dcc_dll_lock_req (ms_tx_dcc_dll_lock_req_sync),
        .i_ms_tx_dcc_cal_done     (ms_tx_dcc_cal_done_sync),
        .i_sl_rx_dll_lock         (sl_rx_dll_lock_sync),
        .i_sl_rx_transfer_en      (sl_rx_transfer_en_sync),
        .o_tx_async_rst           (o_ms_tx_async_rst),
        .o_tx_dcc_cal_req         (o_ms_tx_dcc_cal_req),
        .o_tx_dcc_cal_done        (o_ms_tx_dcc_cal_done),
        .o_tx_transfer_en         (o_ms_tx_transfer_en)
    );

endmodule

/* test/tb_aib_sm.sv */
/*
 * Directed testbench for the AIB master reset and calibration sequencer.
 * Steps through reset, the oscillator handshake, RX and TX calibration
 * and both abort paths. Outputs are checked at falling clock edges.
 */

`timescale 1ns/1ns

module tb_aib_sm
    import aib_sm_pkg::*;
();

    localparam int         WAIT_LIMIT  = 100;  // Cycles per wait
    localparam logic [3:0] OSC_EN      = 4'd9; // Bit positions in all_flags
    localparam logic [3:0] OSC_ALIVE   = 4'd8;
    localparam logic [3:0] RX_ASYNC    = 4'd7;
    localparam logic [3:0] RX_LOCK_REQ = 4'd6;
    localparam logic [3:0] RX_LOCK     = 4'd5;
    localparam logic [3:0] RX_XFER     = 4'd4;
    localparam logic [3:0] TX_ASYNC    = 4'd3;
    localparam logic [3:0] TX_CAL_DONE = 4'd1;
    localparam logic [3:0] TX_XFER     = 4'd0;

    logic osc_clk;
    logic i_reset_n;
    logic i_config_done;
    logic i_sl_osc_transfer_en;
    logic i_sl_tx_dcc_dll_lock_req;
    logic i_ms_rx_dcc_dll_lock_req;
    logic i_ms_rx_dll_lock;
    logic i_sl_tx_dcc_cal_done;
    logic i_sl_rx_dcc_dll_lock_req;
    logic i_ms_tx_dcc_dll_lock_req;
    logic i_ms_tx_dcc_cal_done;
    logic i_sl_rx_dll_lock;
    logic i_sl_rx_transfer_en;
    logic o_ms_osc_transfer_en;
    logic o_ms_osc_transfer_alive;
    logic o_ms_rx_async_rst;
    logic o_ms_rx_dll_lock_req;
    logic o_ms_rx_dll_lock;
    logic o_ms_rx_transfer_en;
    logic o_ms_tx_async_rst;
    logic o_ms_tx_dcc_cal_req;
    logic o_ms_tx_dcc_cal_done;
    logic o_ms_tx_transfer_en;
    logic [1:0] osc_flags;
    logic [3:0] rx_flags;
    logic [3:0] tx_flags;
    logic [9:0] all_flags;

    assign osc_flags = {o_ms_osc_transfer_en, o_ms_osc_transfer_alive};
    assign rx_flags  = {o_ms_rx_async_rst, o_ms_rx_dll_lock_req, o_ms_rx_dll_lock,
                        o_ms_rx_transfer_en};
    assign tx_flags  = {o_ms_tx_async_rst, o_ms_tx_dcc_cal_req, o_ms_tx_dcc_cal_done,
                        o_ms_tx_transfer_en};
    assign all_flags = {osc_flags, rx_flags, tx_flags};

    aib_sm_top aib_sm_top_inst (.*);

    initial begin
        osc_clk = 1'b0;
        forever #2 osc_clk = ~osc_clk;
    end

    // ======================================================================
    // Failure reporting and checks
    // ======================================================================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "Run stopped at first failure");
    endtask

    task automatic check_osc_flags(input logic [1:0] exp, input string step);
        if (osc_flags !== exp)
            abort_run($sformatf("** Error @ %0t: %s: osc en/alive expected %b got %b",
                                $time, step, exp, osc_flags));
    endtask

    task automatic check_rx_flags(input logic [3:0] exp, input string step);
        if (rx_flags !== exp)
            abort_run($sformatf("** Error @ %0t: %s: RX flags expected %b got %b",
                                $time, step, exp, rx_flags));
    endtask

    task automatic check_tx_flags(input logic [3:0] exp, input string step);
        if (tx_flags !== exp)
            abort_run($sformatf("** Error @ %0t: %s: TX flags expected %b got %b",
                                $time, step, exp, tx_flags));
    endtask

    task automatic check_all_flags(input logic [1:0] osc, input logic [3:0] rx,
                                   input logic [3:0] tx, input string step);
        check_osc_flags(osc, step);
        check_rx_flags(rx, step);
        check_tx_flags(tx, step);
    endtask

    // Outputs must hold for the whole stretch
    task automatic check_steady(input int cycles, input logic [1:0] osc,
                                input logic [3:0] rx, input logic [3:0] tx, input string step);
        repeat (cycles) begin
            @(negedge osc_clk);
            check_all_flags(osc, rx, tx, step);
        end
    endtask

    task automatic wait_for_level(input logic [3:0] idx, input logic level, input string step);
        int waited;
        waited = 0;
        @(negedge osc_clk);
        while (all_flags[idx] !== level) begin
            if (waited == WAIT_LIMIT)
                abort_run($sformatf("Timeout: %s, output bit %0d did not reach %b in %0d cycles",
                                    step, idx, level, WAIT_LIMIT));
            waited++;
            @(negedge osc_clk);
        end
    endtask

    function automatic int random_gap();
        return int'($urandom % 11);
    endfunction

    // TX sequence, started by the second request
    task automatic run_tx_sequence(input logic [3:0] rx_exp);
        @(posedge osc_clk);
        i_sl_rx_dcc_dll_lock_req <= 1'b1;
        wait_for_level(TX_ASYNC, 1'b1, "TX start");
        check_all_flags(2'b11, rx_exp, 4'b1100, "TX cal request");
        check_steady(SYNC_STAGES + 3 + random_gap(), 2'b11, rx_exp, 4'b1100, "TX wait cal");
        @(posedge osc_clk);
        i_ms_tx_dcc_cal_done <= 1'b1;
        wait_for_level(TX_CAL_DONE, 1'b1, "TX cal done");
        check_all_flags(2'b11, rx_exp, 4'b1110, "TX cal done");
        @(posedge osc_clk);
        i_sl_rx_dll_lock <= 1'b1; // Transfer enable still needs remote RX enable
        check_steady(SYNC_STAGES + 3 + random_gap(), 2'b11, rx_exp, 4'b1110, "TX wait xfer");
        @(posedge osc_clk);
        i_sl_rx_transfer_en <= 1'b1;
        wait_for_level(TX_XFER, 1'b1, "TX transfer enable");
        check_all_flags(2'b11, rx_exp, 4'b1111, "TX transfer enable");
        check_steady(4, 2'b11, rx_exp, 4'b1111, "TX done");
    endtask

    // ======================================================================
    // Run sequence
    // ======================================================================
    initial begin
        void'($urandom(32'h222d_6e9f));
        i_reset_n                = 1'b0;
        i_config_done            = 1'b0;
        i_sl_osc_transfer_en     = 1'b0;
        i_sl_tx_dcc_dll_lock_req = 1'b0;
        i_ms_rx_dcc_dll_lock_req = 1'b0;
        i_ms_rx_dll_lock         = 1'b0;
        i_sl_tx_dcc_cal_done     = 1'b0;
        i_sl_rx_dcc_dll_lock_req = 1'b0;
        i_ms_tx_dcc_dll_lock_req = 1'b0;
        i_ms_tx_dcc_cal_done     = 1'b0;
        i_sl_rx_dll_lock         = 1'b0;
        i_sl_rx_transfer_en      = 1'b0;

        check_steady(8, 2'b00, 4'b0000, 4'b0000, "in reset");
        @(posedge osc_clk);
        i_reset_n <= 1'b1;
        check_steady(10, 2'b00, 4'b0000, 4'b0000, "config not done");

        // Oscillator handshake
        @(posedge osc_clk);
        i_config_done <= 1'b1;
        wait_for_level(OSC_EN, 1'b1, "osc transfer enable");
        check_all_flags(2'b10, 4'b0000, 4'b0000, "osc transfer enable");
        check_steady(SYNC_STAGES + 3 + random_gap(), 2'b10, 4'b0000, 4'b0000, "osc wait");
        @(posedge osc_clk);
        i_sl_osc_transfer_en <= 1'b1;
        wait_for_level(OSC_ALIVE, 1'b1, "osc alive");
        @(posedge osc_clk);
        i_sl_osc_transfer_en <= 1'b0;
        check_steady(SYNC_STAGES + 3 + random_gap(), 2'b11, 4'b0000, 4'b0000, "alive sticky");

        // RX calibration
        @(posedge osc_clk);
        i_sl_tx_dcc_dll_lock_req <= 1'b1;
        i_ms_rx_dcc_dll_lock_req <= 1'b1;
        wait_for_level(RX_ASYNC, 1'b1, "RX start");
        check_steady(SYNC_STAGES + 3 + random_gap(), 2'b11, 4'b1000, 4'b0000, "RX wait DCC");
        @(posedge osc_clk);
        i_sl_tx_dcc_cal_done <= 1'b1;
        wait_for_level(RX_LOCK_REQ, 1'b1, "RX lock request");
        check_steady(SYNC_STAGES + 3 + random_gap(), 2'b11, 4'b1100, 4'b0000, "RX wait DLL");
        @(posedge osc_clk);
        i_ms_rx_dll_lock <= 1'b1;
        wait_for_level(RX_LOCK, 1'b1, "RX DLL lock");
        check_all_flags(2'b11, 4'b1110, 4'b0000, "RX DLL lock");
        wait_for_level(RX_XFER, 1'b1, "RX transfer enable");
        check_steady(SYNC_STAGES + 3, 2'b11, 4'b1111, 4'b0000, "RX done");

        // TX calibration, one request alone must not start it
        @(posedge osc_clk);
        i_ms_tx_dcc_dll_lock_req <= 1'b1;
        check_steady(SYNC_STAGES + 3 + random_gap(), 2'b11, 4'b1111, 4'b0000, "one TX request");
        run_tx_sequence(4'b1111);

        // RX abort while TX is done
        @(posedge osc_clk);
        i_ms_rx_dcc_dll_lock_req <= 1'b0;
        wait_for_level(RX_ASYNC, 1'b0, "RX abort");
        check_all_flags(2'b11, 4'b0000, 4'b1111, "RX abort");
        @(posedge osc_clk);
        i_sl_tx_dcc_dll_lock_req <= 1'b0; // Single request restarts RX briefly
        repeat (SYNC_STAGES + 3) begin
            @(negedge osc_clk);
            check_tx_flags(4'b1111, "RX abort settling");
        end
        check_steady(4 + random_gap(), 2'b11, 4'b0000, 4'b1111, "RX idle");

        // TX abort, then the full sequence again
        @(posedge osc_clk);
        i_sl_rx_dcc_dll_lock_req <= 1'b0;
        wait_for_level(TX_ASYNC, 1'b0, "TX abort");
        check_all_flags(2'b11, 4'b0000, 4'b0000, "TX abort");
        @(posedge osc_clk);
        i_ms_tx_dcc_cal_done <= 1'b0;
        i_sl_rx_dll_lock     <= 1'b0;
        i_sl_rx_transfer_en  <= 1'b0;
        check_steady(SYNC_STAGES + 3 + random_gap(), 2'b11, 4'b0000, 4'b0000, "TX idle");
        run_tx_sequence(4'b0000);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* aib_sm.f */
verilog/aib_sm_pkg.sv
verilog/aib_reset_sync.sv
verilog/aib_status_sync.sv
verilog/aib_osc_sm.sv
verilog/aib_rx_cal_sm.sv
verilog/aib_tx_cal_sm.sv
verilog/aib_sm_top.sv
test/tb_aib_sm.sv

/* Makefile */
# Verilator flow for the AIB master sequencer testbench
VERILATOR ?= verilator
TOP       ?= tb_aib_sm
FILELIST  ?= aib_sm.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
